// ==== rtl/pim_ctrl_config.svh ====
`ifndef PIM_CTRL_CONFIG_SVH
`define PIM_CTRL_CONFIG_SVH

// Bus register map, one word each
`define PIM_MODE_ADDR    32'h4100_0000
`define PIM_ZP_ADDR      32'h4200_0000
`define PIM_STATUS_ADDR  32'h4300_0000

// Upper address half of a cell-addressed setup write
`define PIM_CELL_PAGE    16'h4000

// Operation codes carried in mode data bits 2..0
`define PIM_OP_ERASE     3'd1
`define PIM_OP_PROGRAM   3'd2
`define PIM_OP_READ      3'd3
`define PIM_OP_ZP        3'd4

// Length of the read execution window in cycles
`define PIM_READ_CYCLES  4'd9

`endif

// ==== rtl/pim_ctrl_pkg.sv ====
package pim_ctrl_pkg;

    // Bus side
    typedef logic [31:0] bus_word_t;

    // Command fields
    typedef logic [2:0]  pim_op_t;
    typedef logic [6:0]  row_addr_t;
    typedef logic [8:0]  col_addr_t;
    typedef logic [16:0] pulse_width_t;
    typedef logic [4:0]  pulse_count_t;

    // Read window counter
    typedef logic [3:0]  exec_cnt_t;

    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,
        CTRL_SETUP = 2'd1,
        CTRL_EXEC  = 2'd2
    } ctrl_state_e;

endpackage

// ==== rtl/pim_bus_decode.sv ====
`timescale 1ns/10ps

`include "pim_ctrl_config.svh"

module pim_bus_decode import pim_ctrl_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,

    input  logic         bus_valid_i,
    input  bus_word_t    bus_addr_i,
    input  bus_word_t    bus_data_i,

    input  ctrl_state_e  state_i,

    output logic         mode_wr_o,
    output logic         cell_wr_o,
    output logic         zp_wr_o,

    output pim_op_t      op_o,
    output row_addr_t    row_o,
    output col_addr_t    col_o,
    output pulse_width_t width_o,
    output pulse_count_t count_o,

    output bus_word_t    data_o
);

    logic      mode_hit;
    logic      cell_hit;
    logic      zp_hit;
    logic      status_hit;
    logic      code_ok;
    logic      op_is_cell;
    pim_op_t   op_q;
    pim_op_t   wr_code;
    row_addr_t row_q;
    col_addr_t col_q;
    pulse_width_t width_q;
    pulse_count_t count_q;
    bus_word_t data_q;

    assign wr_code = bus_data_i[2:0];

    // Address matches, qualified by the strobe
    assign mode_hit   = bus_valid_i && (bus_addr_i == `PIM_MODE_ADDR);
    assign zp_hit     = bus_valid_i && (bus_addr_i == `PIM_ZP_ADDR);
    assign status_hit = bus_valid_i && (bus_addr_i == `PIM_STATUS_ADDR);
    assign cell_hit   = bus_valid_i && (bus_addr_i[31:16] == `PIM_CELL_PAGE);

    assign code_ok = (wr_code == `PIM_OP_ERASE)   ||
                     (wr_code == `PIM_OP_PROGRAM) ||
                     (wr_code == `PIM_OP_READ)    ||
                     (wr_code == `PIM_OP_ZP);

    // Operations whose setup write goes to the cell page
    assign op_is_cell = (op_q == `PIM_OP_ERASE)   ||
                        (op_q == `PIM_OP_PROGRAM) ||
                        (op_q == `PIM_OP_READ);

    assign mode_wr_o = mode_hit && code_ok && (state_i == CTRL_IDLE);
    assign cell_wr_o = cell_hit && op_is_cell && (state_i == CTRL_SETUP);
    assign zp_wr_o   = zp_hit && (op_q == `PIM_OP_ZP) && (state_i == CTRL_SETUP);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            op_q <= '0;
        end else if (mode_wr_o) begin
            op_q <= wr_code;
        end
    end

    // Cell fields from the setup write
    always_ff @(posedge clk_i) begin
        if (cell_wr_o) begin
            row_q <= bus_addr_i[15:9];
            col_q <= bus_addr_i[8:0];
            if (op_q == `PIM_OP_READ) begin
                // read carries no pulse train
                width_q <= '0;
                count_q <= '0;
            end else begin
                width_q <= bus_data_i[21:5];
                count_q <= bus_data_i[4:0];
            end
        end
    end

    // Status word, idle flag in bit 0
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            data_q <= '0;
        end else if (status_hit) begin
            data_q <= {31'b0, (state_i == CTRL_IDLE)};
        end else begin
            data_q <= '0;
        end
    end

    assign op_o    = op_q;
    assign row_o   = row_q;
    assign col_o   = col_q;
    assign width_o = width_q;
    assign count_o = count_q;
    assign data_o  = data_q;

endmodule

// ==== rtl/pim_exec_timer.sv ====
`timescale 1ns/10ps

`include "pim_ctrl_config.svh"

module pim_exec_timer import pim_ctrl_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,

    input  logic         start_i,
    input  pim_op_t      op_i,
    input  pulse_width_t width_i,
    input  pulse_count_t count_i,

    output logic         pulse_on_o,
    output exec_cnt_t    read_cnt_o,
    output logic         done_o
);

    logic         train_run_q;
    pulse_width_t width_cnt_q;
    pulse_count_t pulse_cnt_q;
    pulse_count_t pulse_cnt_nxt;
    exec_cnt_t    read_cnt_q;
    logic         start_read;
    logic         train_zero;
    logic         pulse_end;
    logic         train_last;
    logic         train_done;
    logic         read_done;

    assign start_read = start_i && (op_i == `PIM_OP_READ);

    // Width and count arrive one edge after start, so the train counts up
    assign pulse_cnt_nxt = pulse_cnt_q + 5'd1;
    assign train_zero    = (width_i == '0) || (count_i == '0);
    assign pulse_end     = (width_cnt_q == width_i);
    assign train_last    = pulse_end && (pulse_cnt_nxt == count_i);
    assign train_done    = train_run_q && (train_zero || train_last);

    assign read_done = (read_cnt_q == 4'd1);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            train_run_q <= 1'b0;
            width_cnt_q <= '0;
            pulse_cnt_q <= '0;
        end else if (start_i && !start_read) begin
            train_run_q <= 1'b1;
            width_cnt_q <= '0;
            pulse_cnt_q <= '0;
        end else if (train_done) begin
            train_run_q <= 1'b0;
            width_cnt_q <= '0;
            pulse_cnt_q <= '0;
        end else if (train_run_q) begin
            if (pulse_end) begin
                // Gap cycle over, next pulse
                width_cnt_q <= '0;
                pulse_cnt_q <= pulse_cnt_nxt;
            end else begin
                width_cnt_q <= width_cnt_q + 17'd1;
            end
        end
    end

    // Read window counts down to zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            read_cnt_q <= '0;
        end else if (start_read) begin
            read_cnt_q <= `PIM_READ_CYCLES;
        end else if (read_cnt_q != '0) begin
            read_cnt_q <= read_cnt_q - 4'd1;
        end
    end

    assign pulse_on_o = (train_run_q && (count_i != '0) && (width_cnt_q < width_i)) ||
                        (read_cnt_q != '0);
    assign read_cnt_o = read_cnt_q;
    assign done_o     = train_done || read_done;

endmodule

// ==== rtl/pim_op_ctrl.sv ====
`timescale 1ns/10ps

module pim_op_ctrl import pim_ctrl_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,

    input  logic         mode_wr_i,
    input  logic         cell_wr_i,
    input  logic         zp_wr_i,
    input  pim_op_t      op_i,
    input  row_addr_t    row_i,
    input  col_addr_t    col_i,
    input  bus_word_t    bus_data_i,

    input  logic         pulse_on_i,
    input  exec_cnt_t    read_cnt_i,
    input  logic         done_i,

    output ctrl_state_e  state_o,
    output logic         start_o,

    output logic         pim_en_o,
    output pim_op_t      pim_mode_o,
    output row_addr_t    row_addr_o,
    output col_addr_t    col_addr_o,
    output exec_cnt_t    exec_cnt_o,

    output logic         zp_en_o,
    output bus_word_t    zp_data_o
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        zp_en_q;
    bus_word_t   zp_data_q;
    logic        in_exec;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE: begin
                if (mode_wr_i) begin
                    state_d = CTRL_SETUP;
                end
            end
            CTRL_SETUP: begin
                if (cell_wr_i) begin
                    state_d = CTRL_EXEC;
                end else if (zp_wr_i) begin
                    // zero point needs no execution phase
                    state_d = CTRL_IDLE;
                end
            end
            CTRL_EXEC: begin
                if (done_i) begin
                    state_d = CTRL_IDLE;
                end
            end
            default: begin
                state_d = CTRL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= CTRL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign start_o = cell_wr_i && (state_q == CTRL_SETUP);
    assign state_o = state_q;

    // Array drivers are quiet outside EXEC
    assign in_exec    = (state_q == CTRL_EXEC);
    assign pim_en_o   = in_exec && pulse_on_i;
    assign pim_mode_o = in_exec ? op_i : '0;
    assign row_addr_o = in_exec ? row_i : '0;
    assign col_addr_o = in_exec ? col_i : '0;
    assign exec_cnt_o = in_exec ? read_cnt_i : '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            zp_en_q <= 1'b0;
        end else begin
            zp_en_q <= zp_wr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (zp_wr_i) begin
            zp_data_q <= bus_data_i;
        end
    end

    assign zp_en_o   = zp_en_q;
    assign zp_data_o = zp_data_q;

endmodule

// ==== rtl/pim_peri_ctrl.sv ====
`timescale 1ns/10ps

module pim_peri_ctrl import pim_ctrl_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,

    // Core bus
    input  logic      bus_valid_i,
    input  bus_word_t bus_addr_i,
    input  bus_word_t bus_data_i,
    output bus_word_t data_o,

    // Row and column drivers
    output logic      pim_en_o,
    output pim_op_t   pim_mode_o,
    output row_addr_t row_addr_o,
    output col_addr_t col_addr_o,
    output exec_cnt_t exec_cnt_o,

    // Zero point
    output logic      zp_en_o,
    output bus_word_t zp_data_o
);

    logic         mode_wr;
    logic         cell_wr;
    logic         zp_wr;
    pim_op_t      op;
    row_addr_t    row;
    col_addr_t    col;
    pulse_width_t width;
    pulse_count_t count;
    ctrl_state_e  state;
    logic         start;
    logic         pulse_on;
    exec_cnt_t    read_cnt;
    logic         done;

    pim_bus_decode u_bus_decode (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .bus_valid_i (bus_valid_i),
        .bus_addr_i  (bus_addr_i),
        .bus_data_i  (bus_data_i),
        .state_i     (state),
        .mode_wr_o   (mode_wr),
        .cell_wr_o   (cell_wr),
        .zp_wr_o     (zp_wr),
        .op_o        (op),
        .row_o       (row),
        .col_o       (col),
        .width_o     (width),
        .count_o     (count),
        .data_o      (data_o)
    );

    pim_exec_timer u_exec_timer (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .start_i    (start),
        .op_i       (op),
        .width_i    (width),
        .count_i    (count),
        .pulse_on_o (pulse_on),
        .read_cnt_o (read_cnt),
        .done_o     (done)
    );

    pim_op_ctrl u_op_ctrl (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .mode_wr_i  (mode_wr),
        .cell_wr_i  (cell_wr),
        .zp_wr_i    (zp_wr),
        .op_i       (op),
        .row_i      (row),
        .col_i      (col),
        .bus_data_i (bus_data_i),
        .pulse_on_i (pulse_on),
        .read_cnt_i (read_cnt),
        .done_i     (done),
        .state_o    (state),
        .start_o    (start),
        .pim_en_o   (pim_en_o),
        .pim_mode_o (pim_mode_o),
        .row_addr_o (row_addr_o),
        .col_addr_o (col_addr_o),
        .exec_cnt_o (exec_cnt_o),
        .zp_en_o    (zp_en_o),
        .zp_data_o  (zp_data_o)
    );

endmodule

// ==== test/pim_peri_ctrl_sva.sv ====
`timescale 1ns/10ps

module pim_peri_ctrl_sva import pim_ctrl_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      pim_en_i,
    input  pim_op_t   pim_mode_i,
    input  row_addr_t row_addr_i,
    input  col_addr_t col_addr_i,
    input  exec_cnt_t exec_cnt_i,
    input  logic      zp_en_i
);

    // Number of assertion failures so far
    int unsigned fail_cnt = 0;

    // Zero point strobe is a single pulse
    zp_single: assert property (
        @(posedge clk_i) disable iff (!rst_ni) zp_en_i |=> !zp_en_i
    ) else begin
        fail_cnt++;
        $error("zp_en_o stayed high for more than one cycle");
    end

    // Read counter only runs inside the enable window
    cnt_in_window: assert property (
        @(posedge clk_i) disable iff (!rst_ni) (exec_cnt_i != '0) |-> pim_en_i
    ) else begin
        fail_cnt++;
        $error("exec_cnt_o nonzero while pim_en_o is low");
    end

    // Drivers must not move under an active pulse
    drv_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (pim_en_i && $past(pim_en_i)) |->
            ($stable(pim_mode_i) && $stable(row_addr_i) && $stable(col_addr_i))
    ) else begin
        fail_cnt++;
        $error("mode, row or column changed while pim_en_o was high");
    end

endmodule

bind pim_peri_ctrl pim_peri_ctrl_sva u_sva (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .pim_en_i   (pim_en_o),
    .pim_mode_i (pim_mode_o),
    .row_addr_i (row_addr_o),
    .col_addr_i (col_addr_o),
    .exec_cnt_i (exec_cnt_o),
    .zp_en_i    (zp_en_o)
);

// ==== test/pim_peri_ctrl_tb.sv ====
`timescale 1ns/10ps

`include "pim_ctrl_config.svh"

module pim_peri_ctrl_tb import pim_ctrl_pkg::*; ();

    // About 20 operations of up to 40 cycles plus margin
    localparam int unsigned MAX_CYCLES = 3000;

    logic        clk_i;
    logic        rst_ni;
    logic        bus_valid_i;
    bus_word_t   bus_addr_i;
    bus_word_t   bus_data_i;
    bus_word_t   data_o;
    logic        pim_en_o;
    pim_op_t     pim_mode_o;
    row_addr_t   row_addr_o;
    col_addr_t   col_addr_o;
    exec_cnt_t   exec_cnt_o;
    logic        zp_en_o;
    bus_word_t   zp_data_o;
    logic [31:0] rng;
    int unsigned cycle_cnt = 0;

    pim_peri_ctrl u_dut (.*);

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    always @(negedge clk_i) begin
        if (u_dut.u_sva.fail_cnt != 0) begin
            $display("A protocol assertion on the DUT outputs failed");
            $display("Errors found");
            $fatal(1, "protocol assertion failure");
        end
    end

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp == act) else begin
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
            $display("Errors found");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic bus_write(input bus_word_t addr, input bus_word_t data);
        @(posedge clk_i);
        bus_valid_i <= 1'b1;
        bus_addr_i  <= addr;
        bus_data_i  <= data;
        @(posedge clk_i);
        bus_valid_i <= 1'b0;
        bus_addr_i  <= '0;
        bus_data_i  <= '0;
    endtask

    task automatic status_read(input string name, input logic [31:0] exp);
        bus_write(`PIM_STATUS_ADDR, '0);
        @(negedge clk_i);
        check_value(name, exp, data_o);
    endtask

    task automatic pulse_train_op(input string name, input pim_op_t op,
                                  input row_addr_t row, input col_addr_t col,
                                  input int width, input int count, input bit inject);
        int   len;
        int   rises;
        logic prev;
        len   = count * (width + 1);
        rises = 0;
        prev  = 1'b0;
        bus_write(`PIM_MODE_ADDR, {29'b0, op});
        if (inject) begin
            // Zero point address is the wrong setup target here
            bus_write(`PIM_ZP_ADDR, 32'h1234_5678);
        end
        bus_write({`PIM_CELL_PAGE, row, col}, {10'b0, width[16:0], count[4:0]});
        // Status poll in the first EXEC cycle
        bus_valid_i <= 1'b1;
        bus_addr_i  <= `PIM_STATUS_ADDR;
        for (int k = 0; k < len; k++) begin
            @(negedge clk_i);
            check_value({name, " en"}, (k % (width + 1)) < width, pim_en_o);
            check_value({name, " mode"}, op, pim_mode_o);
            check_value({name, " row"}, row, row_addr_o);
            check_value({name, " col"}, col, col_addr_o);
            check_value({name, " cnt"}, 0, exec_cnt_o);
            if (k == 1) begin
                check_value({name, " busy"}, 0, data_o);
            end
            if (pim_en_o && !prev) begin
                rises++;
            end
            prev = pim_en_o;
            @(posedge clk_i);
            // Mode write and then cell write while busy
            bus_valid_i <= inject && (k < 2);
            bus_addr_i  <= (k == 0) ? `PIM_MODE_ADDR : {`PIM_CELL_PAGE, 16'h0000};
            bus_data_i  <= 32'h0000_0fe3;
        end
        bus_valid_i <= 1'b0;
        @(negedge clk_i);
        check_value({name, " done en"}, 0, pim_en_o);
        check_value({name, " rises"}, count, rises);
        status_read({name, " idle"}, 1);
    endtask

    task automatic random_pulse_op(input string name, input bit inject);
        pim_op_t op;
        rng = next_rand(rng);
        op  = rng[21] ? `PIM_OP_PROGRAM : `PIM_OP_ERASE;
        pulse_train_op(name, op, rng[15:9], rng[8:0], int'(rng[18:16]) + 1,
                       int'(rng[20:19]) + 1, inject);
    endtask

    task automatic read_window_op(input string name, input row_addr_t row,
                                  input col_addr_t col);
        bus_write(`PIM_MODE_ADDR, {29'b0, `PIM_OP_READ});
        bus_write({`PIM_CELL_PAGE, row, col}, 32'h003f_ffff);
        for (int k = 0; k < `PIM_READ_CYCLES; k++) begin
            @(negedge clk_i);
            check_value({name, " en"}, 1, pim_en_o);
            check_value({name, " cnt"}, `PIM_READ_CYCLES - k, exec_cnt_o);
            check_value({name, " row"}, row, row_addr_o);
            check_value({name, " col"}, col, col_addr_o);
        end
        @(negedge clk_i);
        check_value({name, " done en"}, 0, pim_en_o);
        check_value({name, " done cnt"}, 0, exec_cnt_o);
        status_read({name, " idle"}, 1);
    endtask

    task automatic zero_point_op(input string name, input bus_word_t data);
        bus_write(`PIM_MODE_ADDR, {29'b0, `PIM_OP_ZP});
        bus_write(`PIM_ZP_ADDR, data);
        @(negedge clk_i);
        check_value({name, " strobe"}, 1, zp_en_o);
        check_value({name, " data"}, data, zp_data_o);
        check_value({name, " en"}, 0, pim_en_o);
        @(negedge clk_i);
        check_value({name, " strobe end"}, 0, zp_en_o);
        check_value({name, " en after"}, 0, pim_en_o);
        status_read({name, " idle"}, 1);
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        bus_valid_i = 1'b0;
        bus_addr_i  = '0;
        bus_data_i  = '0;
        rng         = 32'd28;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;

        @(negedge clk_i);
        check_value("reset en", 0, pim_en_o);
        check_value("reset mode", 0, pim_mode_o);
        check_value("reset row", 0, row_addr_o);
        check_value("reset col", 0, col_addr_o);
        check_value("reset zp", 0, zp_en_o);
        check_value("reset cnt", 0, exec_cnt_o);
        check_value("reset data", 0, data_o);
        status_read("reset status", 1);

        for (int i = 0; i < 8; i++) begin
            random_pulse_op("pulse train", 1'b0);
        end

        // Unsupported codes and a stray cell write leave it idle
        bus_write(`PIM_MODE_ADDR, 32'h0000_0005);
        bus_write(`PIM_MODE_ADDR, 32'h0000_0000);
        bus_write({`PIM_CELL_PAGE, 16'h1234}, 32'h0000_0021);
        status_read("ignored writes", 1);
        random_pulse_op("busy writes", 1'b1);
        random_pulse_op("after ignored", 1'b0);

        rng = next_rand(rng);
        read_window_op("read", rng[15:9], rng[8:0]);
        rng = next_rand(rng);
        zero_point_op("zero point", rng);

        // Zero count gives no pulse
        bus_write(`PIM_MODE_ADDR, {29'b0, `PIM_OP_PROGRAM});
        bus_write({`PIM_CELL_PAGE, 16'h0a05}, {10'b0, 17'd5, 5'd0});
        repeat (2) begin
            @(negedge clk_i);
            check_value("zero count en", 0, pim_en_o);
        end
        status_read("zero count idle", 1);
        random_pulse_op("after zero", 1'b0);

        if (u_dut.u_sva.fail_cnt != 0) begin
            $display("A protocol assertion on the DUT outputs failed");
            $display("Errors found");
            $fatal(1, "protocol assertion failure");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/pim_ctrl_pkg.sv
rtl/pim_bus_decode.sv
rtl/pim_exec_timer.sv
rtl/pim_op_ctrl.sv
rtl/pim_peri_ctrl.sv
test/pim_peri_ctrl_sva.sv
test/pim_peri_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: pim_peri_ctrl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pim_ctrl_pkg.sv
      - rtl/pim_bus_decode.sv
      - rtl/pim_exec_timer.sv
      - rtl/pim_op_ctrl.sv
      - rtl/pim_peri_ctrl.sv
      - target: test
        files:
          - test/pim_peri_ctrl_sva.sv
          - test/pim_peri_ctrl_tb.sv
